//--- include/tlp_defs.svh
`ifndef TLP_DEFS_SVH
`define TLP_DEFS_SVH

// ----------------------------------------------------------------------
// stream geometry
// ----------------------------------------------------------------------

// bits per dword
`define TLP_DW_WIDTH    32

// dwords in one internal tlp word
`define TLP_WORD_DW     4

// ----------------------------------------------------------------------
// core beat byte enables
// ----------------------------------------------------------------------

// both dwords of a 64-bit beat valid
`define TLP_KEEP_FULL   8'hff

// only the low dword valid
`define TLP_KEEP_LOW    8'h0f

// legacy interrupt timer period in clk_pcie cycles
`define TLP_INT_PERIOD  100000

`endif

//--- hdl/tlp_pkg.sv
`include "tlp_defs.svh"

package tlp_pkg;

    // ------------------------------------------------------------------
    // core side, 64-bit axi-stream
    // ------------------------------------------------------------------

    // one core beat, two dwords
    typedef logic [2*`TLP_DW_WIDTH-1:0] qword_t;

    // byte enables of a core beat
    typedef logic [2*`TLP_DW_WIDTH/8-1:0] byte_keep_t;

    // bar hit bits from the rx user field
    typedef logic [6:0] bar_hit_t;

    // ------------------------------------------------------------------
    // internal side, 128-bit tlp stream
    // ------------------------------------------------------------------

    // one tlp word, four dwords
    typedef logic [`TLP_WORD_DW*`TLP_DW_WIDTH-1:0] oword_t;

    // per-dword enables of a tlp word
    typedef logic [`TLP_WORD_DW-1:0] dw_keep_t;

endpackage

//--- hdl/tlp_rx_widen.sv
`timescale 1ns/1ps
`include "tlp_defs.svh"

module tlp_rx_widen (
    input  logic                clk_pcie,
    input  logic                rst,
    // beats from the core, always accepted
    input  tlp_pkg::qword_t     rx_data,
    input  tlp_pkg::byte_keep_t rx_keep,
    input  logic                rx_last,
    input  logic                rx_valid,
    input  tlp_pkg::bar_hit_t   rx_bar_hit,
    // packed words, valid is a single-cycle strobe
    output tlp_pkg::oword_t     tlps_rx_data,
    output tlp_pkg::dw_keep_t   tlps_rx_keep_dw,
    output logic                tlps_rx_first,
    output logic                tlps_rx_last,
    output tlp_pkg::bar_hit_t   tlps_rx_bar_hit,
    output logic                tlps_rx_valid
);

    localparam int cnt_w = $clog2(`TLP_WORD_DW + 1);

    logic [cnt_w-1:0]  dw_cnt;
    logic [cnt_w-1:0]  next_base;
    logic [cnt_w-1:0]  next_cnt;
    logic              first_q;
    logic              last_q;
    logic              word_done;
    tlp_pkg::oword_t   data_q;
    tlp_pkg::bar_hit_t bar_hit_q;

    // a word leaves once it cannot take another two-dword beat,
    // or when the packet has ended
    assign word_done = last_q || (dw_cnt >= cnt_w'(`TLP_WORD_DW - 1));

    // restart at dword 0 while the finished word is presented
    assign next_base = word_done ? '0 : dw_cnt;
    // keep bit 4 set means the upper dword of the beat is valid
    assign next_cnt  = next_base + cnt_w'(1) + cnt_w'(rx_keep[4]);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_cnt  <= '0;
            first_q <= 1'b1;
            last_q  <= 1'b0;
        end else if (rx_valid) begin
            dw_cnt  <= next_cnt;
            first_q <= word_done ? last_q : first_q;
            last_q  <= rx_last;
        end else if (word_done) begin
            dw_cnt  <= '0;
            first_q <= last_q;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            data_q[`TLP_DW_WIDTH*next_base +: 2*`TLP_DW_WIDTH] <= rx_data;
            bar_hit_q <= rx_bar_hit;
        end
    end

    // thermometer keep from the dword count
    always_comb begin
        for (int i = 0; i < `TLP_WORD_DW; i++) begin
            tlps_rx_keep_dw[i] = (dw_cnt > cnt_w'(i));
        end
    end

    assign tlps_rx_data    = data_q;
    assign tlps_rx_first   = first_q;
    assign tlps_rx_last    = last_q;
    assign tlps_rx_bar_hit = bar_hit_q;
    assign tlps_rx_valid   = word_done;

    // one-dword beats only end a packet
    a_short_beat_is_last: assert property (@(posedge clk_pcie) disable iff (rst)
        rx_valid && !rx_keep[4] |-> rx_last)
        else $error("rx beat with one dword is not a last beat");

    // every presented word holds at least dword 0
    a_word_not_empty: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid |-> tlps_rx_keep_dw[0])
        else $error("rx word presented without dword 0");

endmodule

//--- hdl/tlp_tx_narrow.sv
`timescale 1ns/1ps
`include "tlp_defs.svh"

module tlp_tx_narrow (
    input  logic                clk_pcie,
    input  logic                rst,
    // tlp words from the internal side
    input  tlp_pkg::oword_t     tlps_tx_data,
    input  tlp_pkg::dw_keep_t   tlps_tx_keep_dw,
    input  logic                tlps_tx_last,
    input  logic                tlps_tx_valid,
    output logic                tlps_tx_ready,
    // beats to the core
    output tlp_pkg::qword_t     tx_data,
    output tlp_pkg::byte_keep_t tx_keep,
    output logic                tx_last,
    output logic                tx_valid,
    input  logic                tx_ready
);

    localparam int qw_bits = 2*`TLP_DW_WIDTH;

    logic            upper_pend;
    tlp_pkg::qword_t upper_data;
    logic            upper_dw3;
    logic            upper_last;
    logic            two_beat;
    logic            low_xfer;
    logic            hi_dw_kept;

    // dword 2 in use means the word needs a second beat
    assign two_beat = tlps_tx_keep_dw[2];
    assign low_xfer = tlps_tx_valid && tlps_tx_ready && two_beat;

    // ------------------------------------------------------------------
    // beat mux, held upper half wins over the incoming word
    // ------------------------------------------------------------------

    assign tlps_tx_ready = tx_ready && !upper_pend;
    assign tx_valid      = upper_pend || tlps_tx_valid;
    assign tx_data       = upper_pend ? upper_data : tlps_tx_data[qw_bits-1:0];
    assign hi_dw_kept    = upper_pend ? upper_dw3 : tlps_tx_keep_dw[1];
    assign tx_keep       = hi_dw_kept ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
    assign tx_last       = upper_pend ? upper_last : (tlps_tx_last && !two_beat);

    // ------------------------------------------------------------------
    // upper half holding register
    // ------------------------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            upper_pend <= 1'b0;
        end else if (low_xfer) begin
            upper_pend <= 1'b1;
        end else if (tx_ready) begin
            upper_pend <= 1'b0;
        end
    end

    // captured only when the low beat is taken by the core
    always_ff @(posedge clk_pcie) begin
        if (low_xfer) begin
            upper_data <= tlps_tx_data[2*qw_bits-1:qw_bits];
            upper_dw3  <= tlps_tx_keep_dw[3];
            upper_last <= tlps_tx_last;
        end
    end

    // stalled beat must not change until the core takes it
    a_tx_data_stable: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid && !tx_ready |=> $stable(tx_data))
        else $error("tx_data changed while stalled");

endmodule

//--- hdl/legacy_int_gen.sv
`timescale 1ns/1ps
`include "tlp_defs.svh"

module legacy_int_gen #(
    parameter int int_period = `TLP_INT_PERIOD
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic int_rdy,
    output logic int_req
);

    localparam int cnt_w = $clog2(int_period + 1);

    logic [cnt_w-1:0] int_cnt;
    logic             tick;

    // ------------------------------------------------------------------
    // free-running timer, wraps after int_period
    // ------------------------------------------------------------------

    assign tick = (int_cnt == cnt_w'(int_period));

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            int_cnt <= '0;
        end else if (tick) begin
            int_cnt <= '0;
        end else begin
            int_cnt <= int_cnt + cnt_w'(1);
        end
    end

    // ------------------------------------------------------------------
    // request register
    // ------------------------------------------------------------------

    // acceptance beats a tick in the same cycle
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            int_req <= 1'b0;
        end else if (int_req && int_rdy) begin
            int_req <= 1'b0;
        end else if (tick) begin
            int_req <= 1'b1;
        end
    end

    // request only drops after the core has taken it
    a_req_held_until_rdy: assert property (@(posedge clk_pcie) disable iff (rst)
        $fell(int_req) |-> $past(int_req && int_rdy))
        else $error("int_req dropped without int_rdy");

endmodule

//--- hdl/pcie_stream_bridge.sv
`timescale 1ns/1ps
`include "tlp_defs.svh"

module pcie_stream_bridge #(
    parameter int int_period = `TLP_INT_PERIOD
) (
    input  logic                clk_pcie,
    input  logic                rst,

    // receive beats from the core
    input  tlp_pkg::qword_t     rx_data,
    input  tlp_pkg::byte_keep_t rx_keep,
    input  logic                rx_last,
    input  logic                rx_valid,
    input  tlp_pkg::bar_hit_t   rx_bar_hit,

    // received tlp words
    output tlp_pkg::oword_t     tlps_rx_data,
    output tlp_pkg::dw_keep_t   tlps_rx_keep_dw,
    output logic                tlps_rx_first,
    output logic                tlps_rx_last,
    output tlp_pkg::bar_hit_t   tlps_rx_bar_hit,
    output logic                tlps_rx_valid,

    // tlp words to transmit
    input  tlp_pkg::oword_t     tlps_tx_data,
    input  tlp_pkg::dw_keep_t   tlps_tx_keep_dw,
    input  logic                tlps_tx_last,
    input  logic                tlps_tx_valid,
    output logic                tlps_tx_ready,

    // transmit beats to the core
    output tlp_pkg::qword_t     tx_data,
    output tlp_pkg::byte_keep_t tx_keep,
    output logic                tx_last,
    output logic                tx_valid,
    input  logic                tx_ready,

    // legacy interrupt handshake
    input  logic                int_rdy,
    output logic                int_req
);

    // ------------------------------------------------------------------
    // receive widening
    // ------------------------------------------------------------------

    tlp_rx_widen rx_widen0 (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .rx_data         (rx_data),
        .rx_keep         (rx_keep),
        .rx_last         (rx_last),
        .rx_valid        (rx_valid),
        .rx_bar_hit      (rx_bar_hit),
        .tlps_rx_data    (tlps_rx_data),
        .tlps_rx_keep_dw (tlps_rx_keep_dw),
        .tlps_rx_first   (tlps_rx_first),
        .tlps_rx_last    (tlps_rx_last),
        .tlps_rx_bar_hit (tlps_rx_bar_hit),
        .tlps_rx_valid   (tlps_rx_valid)
    );

    // transmit narrowing
    tlp_tx_narrow tx_narrow0 (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .tlps_tx_data    (tlps_tx_data),
        .tlps_tx_keep_dw (tlps_tx_keep_dw),
        .tlps_tx_last    (tlps_tx_last),
        .tlps_tx_valid   (tlps_tx_valid),
        .tlps_tx_ready   (tlps_tx_ready),
        .tx_data         (tx_data),
        .tx_keep         (tx_keep),
        .tx_last         (tx_last),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready)
    );

    // periodic legacy interrupt
    legacy_int_gen #(
        .int_period (int_period)
    ) int_gen0 (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .int_rdy  (int_rdy),
        .int_req  (int_req)
    );

endmodule

//--- sim/tb_pcie_stream_bridge.sv
`timescale 1ns/1ps
`include "tlp_defs.svh"

module tb_pcie_stream_bridge;

    // rough length of all tests in cycles
    localparam int test_cycles = 1000;

    logic                clk_pcie;
    logic                rst;
    tlp_pkg::qword_t     rx_data;
    tlp_pkg::byte_keep_t rx_keep;
    logic                rx_last;
    logic                rx_valid;
    tlp_pkg::bar_hit_t   rx_bar_hit;
    tlp_pkg::oword_t     tlps_rx_data;
    tlp_pkg::dw_keep_t   tlps_rx_keep_dw;
    logic                tlps_rx_first;
    logic                tlps_rx_last;
    tlp_pkg::bar_hit_t   tlps_rx_bar_hit;
    logic                tlps_rx_valid;
    tlp_pkg::oword_t     tlps_tx_data;
    tlp_pkg::dw_keep_t   tlps_tx_keep_dw;
    logic                tlps_tx_last;
    logic                tlps_tx_valid;
    logic                tlps_tx_ready;
    tlp_pkg::qword_t     tx_data;
    tlp_pkg::byte_keep_t tx_keep;
    logic                tx_last;
    logic                tx_valid;
    logic                tx_ready;
    logic                int_rdy;
    logic                int_req;

    integer seed = 32'h4b57;
    int     test_errs;
    int     pass_cnt;
    int     fail_cnt;
    int     tx_words;
    int     cycle;
    // rx record is {bar_hit, first, last, keep_dw, data}
    // tx record is {last, keep, data}
    logic [140:0] rx_exp[$];
    logic [140:0] rx_got[$];
    logic [72:0]  tx_exp[$];
    logic [72:0]  tx_got[$];

    pcie_stream_bridge #(.int_period(20)) dut0 (.*);

    initial begin
        clk_pcie = 1'b0;
        forever #5 clk_pcie = ~clk_pcie;
    end

    initial begin
        repeat (3*test_cycles) @(posedge clk_pcie);
        $display("timeout: tests did not finish within %0d cycles", 3*test_cycles);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // monitors sample mid-cycle
    // ------------------------------------------------------------------

    always @(posedge clk_pcie) begin
        cycle++;
    end

    always @(negedge clk_pcie) begin
        if (!rst && tlps_rx_valid) begin
            rx_got.push_back({tlps_rx_bar_hit, tlps_rx_first, tlps_rx_last,
                              tlps_rx_keep_dw, tlps_rx_data});
        end
        if (!rst && tx_valid && tx_ready) begin
            tx_got.push_back({tx_last, tx_keep, tx_data});
        end
        if (!rst && tlps_tx_valid && tlps_tx_ready) begin
            tx_words++;
        end
    end

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("Fail %0t: %s", $time, what);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ------------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------------

    // drives one packet and queues the words it should produce
    task automatic send_rx_packet(input int n, input tlp_pkg::bar_hit_t bar);
        logic [31:0]  dws[8];
        logic [140:0] word;
        int           nw;
        for (int i = 0; i < n; i++) begin
            dws[i] = $random(seed);
        end
        nw = (n + 3) / 4;
        for (int k = 0; k < nw; k++) begin
            word = '0;
            for (int j = 0; j < 4 && 4*k + j < n; j++) begin
                word[32*j +: 32] = dws[4*k + j];
                word[128 + j]    = 1'b1;
            end
            word[140:134] = bar;
            word[133]     = (k == 0);
            word[132]     = (k == nw - 1);
            rx_exp.push_back(word);
        end
        for (int i = 0; i < n; i += 2) begin
            rx_valid   = 1'b1;
            rx_data    = {(i + 1 < n) ? dws[i + 1] : 32'h0, dws[i]};
            rx_keep    = (i + 1 < n) ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
            rx_last    = (i + 2 >= n);
            rx_bar_hit = bar;
            @(posedge clk_pcie);
            #1;
        end
    endtask

    task automatic rx_idle(input int n);
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        repeat (n) @(posedge clk_pcie);
        #1;
    endtask

    task automatic check_rx_words();
        int waited;
        waited = 0;
        while (rx_got.size() < rx_exp.size() && waited < 40) begin
            @(posedge clk_pcie);
            #1;
            waited++;
        end
        rx_idle(4);
        check(rx_got.size() == rx_exp.size(),
              $sformatf("%0d rx words, expected %0d", rx_got.size(), rx_exp.size()));
        for (int i = 0; i < rx_exp.size() && i < rx_got.size(); i++) begin
            check(rx_got[i][140:128] == rx_exp[i][140:128],
                  $sformatf("rx word %0d flags %h, expected %h", i,
                            rx_got[i][140:128], rx_exp[i][140:128]));
            for (int j = 0; j < 4; j++) begin
                if (rx_exp[i][128 + j]) begin
                    check(rx_got[i][32*j +: 32] == rx_exp[i][32*j +: 32],
                          $sformatf("rx word %0d dword %0d is %h, expected %h", i, j,
                                    rx_got[i][32*j +: 32], rx_exp[i][32*j +: 32]));
                end
            end
        end
        rx_got.delete();
        rx_exp.delete();
    endtask

    task automatic test_reset();
        @(negedge clk_pcie);
        check(!tlps_rx_valid, "tlps_rx_valid high after reset");
        check(!tx_valid, "tx_valid high while tlps_tx_valid is low");
        check(!int_req, "int_req high after reset");
        @(posedge clk_pcie);
        #1;
        finish_test("reset");
    endtask

    task automatic test_rx_widen();
        int sizes[5] = '{1, 3, 4, 5, 8};
        for (int p = 0; p < 5; p++) begin
            send_rx_packet(sizes[p], tlp_pkg::bar_hit_t'(7'h1 << p));
            rx_idle(2);
        end
        check_rx_words();
        finish_test("rx widening");
    endtask

    // second packet starts while the last word of the first is presented
    task automatic test_rx_back_to_back();
        send_rx_packet(5, 7'h20);
        send_rx_packet(4, 7'h40);
        rx_idle(1);
        check_rx_words();
        finish_test("rx back to back");
    endtask

    // ------------------------------------------------------------------
    // transmit path
    // ------------------------------------------------------------------

    task automatic test_tx_narrow();
        tlp_pkg::oword_t   words[6];
        tlp_pkg::dw_keep_t keeps[6] = '{4'h1, 4'h3, 4'h7, 4'hf, 4'hf, 4'h3};
        logic              lasts[6] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
        logic              words_done;
        logic              fire;
        int                waited;
        int                stall;
        tx_words = 0;
        for (int w = 0; w < 6; w++) begin
            words[w] = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (!keeps[w][2]) begin
                tx_exp.push_back({lasts[w], (keeps[w][1] ? `TLP_KEEP_FULL : `TLP_KEEP_LOW),
                                  words[w][63:0]});
            end else begin
                tx_exp.push_back({1'b0, `TLP_KEEP_FULL, words[w][63:0]});
                tx_exp.push_back({lasts[w], (keeps[w][3] ? `TLP_KEEP_FULL : `TLP_KEEP_LOW),
                                  words[w][127:64]});
            end
        end
        words_done = 1'b0;
        fork
            begin
                for (int w = 0; w < 6; w++) begin
                    tlps_tx_valid   = 1'b1;
                    tlps_tx_data    = words[w];
                    tlps_tx_keep_dw = keeps[w];
                    tlps_tx_last    = lasts[w];
                    fire = 1'b0;
                    stall = 0;
                    // give up on a word that is never taken
                    while (!fire && stall < 100) begin
                        @(negedge clk_pcie);
                        fire = tlps_tx_ready;
                        @(posedge clk_pcie);
                        #1;
                        stall++;
                    end
                end
                tlps_tx_valid = 1'b0;
                words_done = 1'b1;
            end
            begin
                // core stalls roughly one cycle in four
                waited = 0;
                while (!(words_done && tx_got.size() >= tx_exp.size()) && waited < 400) begin
                    tx_ready = ($random(seed) % 4) != 0;
                    @(posedge clk_pcie);
                    #1;
                    waited++;
                end
                tx_ready = 1'b0;
            end
        join
        check(tx_words == 6, $sformatf("%0d tx words accepted, expected 6", tx_words));
        check(tx_got.size() == tx_exp.size(),
              $sformatf("%0d tx beats, expected %0d", tx_got.size(), tx_exp.size()));
        for (int i = 0; i < tx_exp.size() && i < tx_got.size(); i++) begin
            check(tx_got[i][72:64] == tx_exp[i][72:64],
                  $sformatf("tx beat %0d last/keep %h, expected %h", i,
                            tx_got[i][72:64], tx_exp[i][72:64]));
            check(tx_got[i][31:0] == tx_exp[i][31:0],
                  $sformatf("tx beat %0d low dword %h, expected %h", i,
                            tx_got[i][31:0], tx_exp[i][31:0]));
            if (tx_exp[i][68]) begin
                check(tx_got[i][63:32] == tx_exp[i][63:32],
                      $sformatf("tx beat %0d high dword %h, expected %h", i,
                                tx_got[i][63:32], tx_exp[i][63:32]));
            end
        end
        tx_got.delete();
        tx_exp.delete();
        finish_test("tx narrowing");
    endtask

    // ------------------------------------------------------------------
    // interrupt
    // ------------------------------------------------------------------

    // cycle count at the first mid-cycle sample where int_req has gone high
    task automatic wait_int_rise(output int at);
        logic prev;
        int   waited;
        at = -1;
        waited = 0;
        @(negedge clk_pcie);
        prev = int_req;
        while (at < 0 && waited < 100) begin
            @(negedge clk_pcie);
            if (int_req && !prev) begin
                at = cycle;
            end
            prev = int_req;
            waited++;
        end
        assert (at >= 0) else begin
            $display("int_req did not rise within 100 cycles");
            test_errs++;
        end
    endtask

    task automatic test_interrupt();
        int t0;
        int t1;
        int_rdy = 1'b1;
        wait_int_rise(t0);
        wait_int_rise(t1);
        check(t1 - t0 == 21, $sformatf("int_req rises %0d cycles apart, expected 21", t1 - t0));
        @(posedge clk_pcie);
        #1;
        int_rdy = 1'b0;
        wait_int_rise(t0);
        repeat (60) begin
            @(negedge clk_pcie);
            check(int_req, "int_req dropped while int_rdy is low");
        end
        @(posedge clk_pcie);
        #1;
        int_rdy = 1'b1;
        @(negedge clk_pcie);
        check(int_req, "int_req dropped before acceptance");
        @(negedge clk_pcie);
        check(!int_req, "int_req still high after acceptance");
        finish_test("interrupt");
    endtask

    initial begin
        rst             = 1'b1;
        rx_data         = '0;
        rx_keep         = `TLP_KEEP_FULL;
        rx_last         = 1'b0;
        rx_valid        = 1'b0;
        rx_bar_hit      = '0;
        tlps_tx_data    = '0;
        tlps_tx_keep_dw = '0;
        tlps_tx_last    = 1'b0;
        tlps_tx_valid   = 1'b0;
        tx_ready        = 1'b0;
        int_rdy         = 1'b0;
        repeat (5) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        test_reset();
        test_rx_widen();
        test_rx_back_to_back();
        test_tx_narrow();
        test_interrupt();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/tlp_pkg.sv
hdl/tlp_rx_widen.sv
hdl/tlp_tx_narrow.sv
hdl/legacy_int_gen.sv
hdl/pcie_stream_bridge.sv
sim/tb_pcie_stream_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pcie_stream_bridge \
    --Mdir obj_dir -o tb_sim \
    -f list.f

# keep going after the run so the log can be searched
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
